// ==== Bender.yml ====
package:
  name: chip_block

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/chip_cfg_pkg.sv
      - verilog/chip_link_pkg.sv
      - verilog/chip_tag_client.sv
      - verilog/chip_link_rx.sv
      - verilog/chip_flit_engine.sv
      - verilog/chip_link_tx.sv
      - verilog/chip_block.sv

  - target: test
    include_dirs:
      - verilog
      - tb
    files:
      - tb/tb_chip_block.sv

// ==== chip_block.f ====
+incdir+verilog
+incdir+tb
verilog/chip_cfg_pkg.sv
verilog/chip_link_pkg.sv
verilog/chip_tag_client.sv
verilog/chip_link_rx.sv
verilog/chip_flit_engine.sv
verilog/chip_link_tx.sv
verilog/chip_block.sv
tb/tb_chip_block.sv

// ==== tb/tb_chip_block_model.svh ====
`ifndef TB_CHIP_BLOCK_MODEL_SVH
`define TB_CHIP_BLOCK_MODEL_SVH

////////////////////////////////////////////////////////////////////////////
// configuration as the tag client should hold it

// disabled with a zero key out of reset
logic                          model_enable = 1'b0;
logic [`CHIP_FLIT_DATA_W-1:0]  model_key    = '0;

// flits sent in and not yet seen on the output link
chip_link_pkg::flit_s          sent_q [$];

// only a full-length frame for this node counts
function automatic void apply_tag_frame
  (input logic [`CHIP_NODE_ID_W-1:0]   id
  ,input logic                         en
  ,input logic [`CHIP_FLIT_DATA_W-1:0] key
  ,input int                           nbits
  );
  if (nbits == `CHIP_TAG_FRAME_LEN && id == node_id_lp)
  begin
    model_enable = en;
    model_key    = key;
  end
endfunction

////////////////////////////////////////////////////////////////////////////
// flit transform

// one bit position per step, msb wraps to bit 0
function automatic logic [`CHIP_FLIT_DATA_W-1:0] rotate_left
  (input logic [`CHIP_FLIT_DATA_W-1:0] d
  ,input int                           amt
  );
  logic [`CHIP_FLIT_DATA_W-1:0] r;
  r = d;
  repeat (amt)
  begin
    r = {r[`CHIP_FLIT_DATA_W-2:0], r[`CHIP_FLIT_DATA_W-1]};
  end
  return r;
endfunction

function automatic logic [`CHIP_FLIT_DATA_W-1:0] transform_data
  (input chip_link_pkg::flit_op_e      op
  ,input logic [`CHIP_FLIT_DATA_W-1:0] data
  ,input logic [`CHIP_FLIT_DATA_W-1:0] key
  );
  case (op)
    chip_link_pkg::OP_ADD:  return data + key;
    chip_link_pkg::OP_XOR:  return data ^ key;
    // amount is the key modulo the word width
    chip_link_pkg::OP_ROTL: return rotate_left(data, int'(key) % `CHIP_FLIT_DATA_W);
    default:                return data;
  endcase
endfunction

// op and id pass through, data takes the key
function automatic chip_link_pkg::flit_s expected_flit(input chip_link_pkg::flit_s sent);
  chip_link_pkg::flit_s f;
  f      = sent;
  f.data = transform_data(sent.op, sent.data, model_key);
  return f;
endfunction

`endif

// ==== tb/tb_chip_block.sv ====
`timescale 1ns/1ps

`include "chip_block_params.svh"

module tb_chip_block;

  localparam logic [`CHIP_NODE_ID_W-1:0] node_id_lp = 4'd5;
  localparam logic [31:0] seed_lp        = 32'h745b_5fb8;
  localparam int          flit_budget_lp = 300;
  localparam int          cycle_limit_lp = flit_budget_lp * 40 + 2000;

  logic                  clk;
  logic                  rst_n;
  logic                  tag_en;
  logic                  tag_data;
  logic                  link_v_in;
  chip_link_pkg::flit_s  link_data_in;
  logic                  link_token_out;
  logic                  link_v_out;
  chip_link_pkg::flit_s  link_data_out;
  logic                  link_token_in;

  // sender and receiver bookkeeping
  logic [31:0]           stim_state;
  logic [31:0]           tok_state;
  logic [3:0]            seq_id;
  logic [3:0]            ops_seen;
  logic                  hold_tokens;
  int                    flits_sent;
  int                    tokens_in;
  int                    out_count;
  int                    owed;
  int                    cycle_cnt;

  `include "tb_chip_block_model.svh"

  chip_block #(.node_id_p(node_id_lp)) dut0
  (.noc_clk_i    (clk           )
  ,.rst_n_i      (rst_n         )
  ,.tag_en_i     (tag_en        )
  ,.tag_data_i   (tag_data      )
  ,.link_v_i     (link_v_in     )
  ,.link_data_i  (link_data_in  )
  ,.link_token_o (link_token_out)
  ,.link_v_o     (link_v_out    )
  ,.link_data_o  (link_data_out )
  ,.link_token_i (link_token_in )
  );

  // 40 ns period
  always #20 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // failure reporting

  task automatic end_with_failure();
    $display(">>> FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic report_mismatch(input string what);
    $display("CHECK FAILED at %0t ns: %s", $time, what);
    end_with_failure();
  endtask

  task automatic report_problem(input string why);
    $display("error at %0t ns: %s", $time, why);
    end_with_failure();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // random numbers

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // stimulus stream, main process only
  function automatic logic [31:0] next_rand();
    stim_state = lcg_step(stim_state);
    return stim_state;
  endfunction

  // upper bits, the low ones cycle fast
  function automatic chip_link_pkg::flit_s random_flit();
    chip_link_pkg::flit_s f;
    logic [31:0]          r;
    r      = next_rand();
    f.op   = chip_link_pkg::flit_op_e'(r[31:30]);
    f.id   = seq_id;
    f.data = r[29:14];
    seq_id = seq_id + 1'b1;
    return f;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // input link sender

  // counters move on NBAs, so reads at the edge see last cycle
  function automatic int credits_left();
    return `CHIP_LINK_CREDITS - flits_sent + tokens_in;
  endfunction

  task automatic send_flit(input chip_link_pkg::flit_s f);
    @(posedge clk);
    while (credits_left() == 0)
    begin
      link_v_in <= 1'b0;
      @(posedge clk);
    end
    link_v_in    <= 1'b1;
    link_data_in <= f;
    flits_sent   <= flits_sent + 1;
    sent_q.push_back(f);
  endtask

  task automatic send_random(input int count, input int max_gap);
    int gap;
    repeat (count)
    begin
      gap = int'(next_rand() >> 16) % (max_gap + 1);
      repeat (gap)
      begin
        @(posedge clk);
        link_v_in <= 1'b0;
      end
      send_flit(random_flit());
    end
    @(posedge clk);
    link_v_in <= 1'b0;
  endtask

  // never blocks, sends only when a credit is free
  task automatic offer_flits(input int cycles);
    repeat (cycles)
    begin
      @(posedge clk);
      if (credits_left() > 0 && next_rand() > 32'h8000_0000)
      begin
        send_flit_now(random_flit());
      end
      else
      begin
        link_v_in <= 1'b0;
      end
    end
    @(posedge clk);
    link_v_in <= 1'b0;
  endtask

  // caller already sits on the edge with a credit
  task automatic send_flit_now(input chip_link_pkg::flit_s f);
    link_v_in    <= 1'b1;
    link_data_in <= f;
    flits_sent   <= flits_sent + 1;
    sent_q.push_back(f);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // tag chain

  // node id, enable, key, msb first
  // a short frame drops its leading bits
  task automatic send_tag_frame
    (input logic [`CHIP_NODE_ID_W-1:0]   id
    ,input logic                         en
    ,input logic [`CHIP_FLIT_DATA_W-1:0] key
    ,input int                           nbits
    );
    logic [`CHIP_TAG_FRAME_LEN-1:0] frame;
    frame = {id, en, key};
    for (int i = 0; i < nbits; i++)
    begin
      @(posedge clk);
      tag_en   <= 1'b1;
      tag_data <= frame[nbits-1-i];
    end
    @(posedge clk);
    tag_en   <= 1'b0;
    tag_data <= 1'b0;
    repeat (2) @(posedge clk);
    apply_tag_frame(id, en, key, nbits);
  endtask

  // everything out and every output token handed back
  // then a few cycles for the last input tokens
  task automatic wait_drained();
    do
    begin
      @(posedge clk);
    end
    while (!(out_count == flits_sent && owed == 0));
    repeat (3) @(posedge clk);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // output link receiver

  always @(posedge clk)
  begin : out_side
    chip_link_pkg::flit_s sent;
    chip_link_pkg::flit_s want;
    int                   owed_next;
    if (!rst_n)
    begin
      owed          <= 0;
      out_count     <= 0;
      ops_seen      <= '0;
      link_token_in <= 1'b0;
    end
    else
    begin
      owed_next = owed;
      if (link_v_out)
      begin
        if (sent_q.size() == 0)
        begin
          report_problem("output link delivered a flit that was never sent in");
        end
        else if (!model_enable)
        begin
          report_problem("output link delivered a flit while the core is disabled");
        end
        else
        begin
          sent = sent_q.pop_front();
          want = expected_flit(sent);
          assert (link_data_out == want)
          else report_mismatch($sformatf("flit id %0d got %h expected %h",
                                         sent.id, link_data_out, want));
          ops_seen[sent.op] <= 1'b1;
          out_count         <= out_count + 1;
          owed_next         = owed_next + 1;
        end
      end
      // about three cycles in four hand a credit back
      tok_state = lcg_step(tok_state);
      if (!hold_tokens && owed_next > 0 && tok_state[31:30] != 2'b00)
      begin
        link_token_in <= 1'b1;
        owed_next     = owed_next - 1;
      end
      else
      begin
        link_token_in <= 1'b0;
      end
      owed <= owed_next;
    end
  end

  // input link tokens back to the sender
  always @(posedge clk)
  begin
    if (rst_n && link_token_out)
    begin
      tokens_in <= tokens_in + 1;
    end
  end

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit_lp)
    begin
      report_problem("timeout, the test did not finish within the cycle limit");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // test sequence

  initial
  begin : main_seq
    logic [`CHIP_FLIT_DATA_W-1:0] key_a;
    int                           base_count;
    clk           = 1'b0;
    rst_n         = 1'b0;
    tag_en        = 1'b0;
    tag_data      = 1'b0;
    link_v_in     = 1'b0;
    link_data_in  = '0;
    link_token_in = 1'b0;
    hold_tokens   = 1'b0;
    stim_state    = seed_lp;
    // receiver side draws from its own stream
    tok_state     = seed_lp ^ 32'h0f0f_0f0f;
    seq_id        = '0;
    flits_sent    = 0;
    tokens_in     = 0;
    cycle_cnt     = 0;

    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    assert (!link_v_out && !link_token_out)
    else report_mismatch("link strobes not low after reset");

    // disabled core holds everything in the FIFO
    send_random(`CHIP_LINK_CREDITS, 0);
    repeat (50)
    begin
      @(posedge clk);
      assert (!link_v_out && !link_token_out)
      else report_mismatch("link activity while the core is disabled");
    end

    // enable with a random key, queued flits drain first
    key_a = 16'(next_rand() >> 16);
    send_tag_frame(node_id_lp, 1'b1, key_a, `CHIP_TAG_FRAME_LEN);
    send_random(80, 2);
    wait_drained();

    // wrong node id
    // key ends in 0, which stays behind in the shift register
    send_tag_frame(node_id_lp + 4'd1, 1'b1, (key_a ^ 16'ha5c3) & 16'hfffe,
                   `CHIP_TAG_FRAME_LEN);
    send_random(40, 2);
    wait_drained();

    // one bit short
    // with that stale zero on top it reads as a full frame for this node
    send_tag_frame(node_id_lp, 1'b1, ~key_a, `CHIP_TAG_FRAME_LEN - 1);
    send_random(40, 2);
    wait_drained();

    // withhold output tokens, tx may spend only its credits
    @(posedge clk);
    hold_tokens <= 1'b1;
    base_count = out_count;
    offer_flits(40);
    repeat (20) @(posedge clk);
    assert (out_count - base_count <= `CHIP_LINK_CREDITS)
    else report_mismatch($sformatf("%0d output strobes with tokens withheld",
                                   out_count - base_count));
    @(posedge clk);
    hold_tokens <= 1'b0;
    wait_drained();

    send_random(30, 1);
    wait_drained();

    // token and credit accounting after the last drain
    assert (tokens_in == flits_sent)
    else report_mismatch($sformatf("%0d input tokens for %0d flits", tokens_in, flits_sent));
    assert (credits_left() == `CHIP_LINK_CREDITS)
    else report_mismatch($sformatf("sender holds %0d credits", credits_left()));
    assert (ops_seen == 4'hf)
    else report_mismatch($sformatf("opcodes seen %b", ops_seen));

    $display(">>> PASS");
    $finish;
  end

endmodule

// ==== verilog/chip_block.sv ====
`timescale 1ns/1ps

`include "chip_block_params.svh"

module chip_block
  #(parameter logic [`CHIP_NODE_ID_W-1:0] node_id_p = '0)
  (input  logic                  noc_clk_i
  ,input  logic                  rst_n_i

  // tag chain
  ,input  logic                  tag_en_i
  ,input  logic                  tag_data_i

  // input link
  ,input  logic                  link_v_i
  ,input  chip_link_pkg::flit_s  link_data_i
  ,output logic                  link_token_o

  // output link
  ,output logic                  link_v_o
  ,output chip_link_pkg::flit_s  link_data_o
  ,input  logic                  link_token_i
  );

  chip_cfg_pkg::core_cfg_s  core_cfg;
  chip_link_pkg::flit_s     rx_flit;
  logic                     rx_avail;
  logic                     rx_pop;
  chip_link_pkg::flit_s     res_flit;
  logic                     res_valid;
  logic                     res_take;

  ////////////////////////////////////////////////////////////////////////////
  // configuration

  chip_tag_client #(.node_id_p(node_id_p)) tag0
  (.noc_clk_i    (noc_clk_i   )
  ,.rst_n_i      (rst_n_i     )
  ,.tag_en_i     (tag_en_i    )
  ,.tag_data_i   (tag_data_i  )
  ,.core_cfg_o   (core_cfg    )
  );

  ////////////////////////////////////////////////////////////////////////////
  // datapath, rx then core then tx

  chip_link_rx rx0
  (.noc_clk_i    (noc_clk_i   )
  ,.rst_n_i      (rst_n_i     )
  ,.link_v_i     (link_v_i    )
  ,.link_data_i  (link_data_i )
  ,.link_token_o (link_token_o)
  ,.rx_flit_o    (rx_flit     )
  ,.rx_avail_o   (rx_avail    )
  ,.rx_pop_i     (rx_pop      )
  );

  chip_flit_engine engine0
  (.noc_clk_i    (noc_clk_i   )
  ,.rst_n_i      (rst_n_i     )
  ,.core_cfg_i   (core_cfg    )
  ,.rx_flit_i    (rx_flit     )
  ,.rx_avail_i   (rx_avail    )
  ,.rx_pop_o     (rx_pop      )
  ,.res_flit_o   (res_flit    )
  ,.res_valid_o  (res_valid   )
  ,.res_take_i   (res_take    )
  );

  chip_link_tx tx0
  (.noc_clk_i    (noc_clk_i   )
  ,.rst_n_i      (rst_n_i     )
  ,.res_flit_i   (res_flit    )
  ,.res_valid_i  (res_valid   )
  ,.res_take_o   (res_take    )
  ,.link_v_o     (link_v_o    )
  ,.link_data_o  (link_data_o )
  ,.link_token_i (link_token_i)
  );

endmodule

// ==== verilog/chip_block_params.svh ====
`ifndef CHIP_BLOCK_PARAMS_SVH
`define CHIP_BLOCK_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// datapath sizing

// flit payload width, also the key width
`define CHIP_FLIT_DATA_W 16

////////////////////////////////////////////////////////////////////////////
// tag chain

// node id field at the head of every tag frame
`define CHIP_NODE_ID_W 4

// node id, then enable bit, then key
`define CHIP_TAG_FRAME_LEN (`CHIP_NODE_ID_W + 1 + `CHIP_FLIT_DATA_W)

////////////////////////////////////////////////////////////////////////////
// links

// sender credits at reset, same as input FIFO depth
`define CHIP_LINK_CREDITS 4

`endif

// ==== verilog/chip_cfg_pkg.sv ====
`include "chip_block_params.svh"

package chip_cfg_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // tag client FSM

  // idle between frames, shift while tag_en_i is high
  typedef enum logic [0:0]
  {
    TAG_IDLE  = 1'b0,
    TAG_SHIFT = 1'b1
  } tag_state_e;

  ////////////////////////////////////////////////////////////////////////////
  // core configuration

  // written by the tag client, read by the flit engine
  // all zero after reset, so the core comes up disabled
  typedef struct packed
  {
    // core may pop flits
    logic                          enable;
    // operand for add, xor and rotate
    logic [`CHIP_FLIT_DATA_W-1:0]  key;
  } core_cfg_s;

endpackage

// ==== verilog/chip_flit_engine.sv ====
`timescale 1ns/1ps

`include "chip_block_params.svh"

module chip_flit_engine
  (input  logic                     noc_clk_i
  ,input  logic                     rst_n_i

  ,input  chip_cfg_pkg::core_cfg_s  core_cfg_i

  // from input link
  ,input  chip_link_pkg::flit_s     rx_flit_i
  ,input  logic                     rx_avail_i
  ,output logic                     rx_pop_o

  // to output link
  ,output chip_link_pkg::flit_s     res_flit_o
  ,output logic                     res_valid_o
  ,input  logic                     res_take_i
  );

  localparam int data_w_lp = `CHIP_FLIT_DATA_W;
  localparam int rot_w_lp  = $clog2(data_w_lp);

  logic [2*data_w_lp-1:0]  rot_wide;
  logic [data_w_lp-1:0]    xf_data;
  logic                    pop;
  logic                    res_valid_r;
  chip_link_pkg::flit_s    res_r;

  ////////////////////////////////////////////////////////////////////////////
  // opcode decode

  always_comb
  begin
    // doubled word, upper half is the left rotate
    rot_wide = {rx_flit_i.data, rx_flit_i.data} << core_cfg_i.key[rot_w_lp-1:0];
    case (rx_flit_i.op)
      chip_link_pkg::OP_ADD:  xf_data = rx_flit_i.data + core_cfg_i.key;
      chip_link_pkg::OP_XOR:  xf_data = rx_flit_i.data ^ core_cfg_i.key;
      chip_link_pkg::OP_ROTL: xf_data = rot_wide[2*data_w_lp-1 -: data_w_lp];
      default:                xf_data = rx_flit_i.data;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // result register

  // take the head when enabled and the slot frees up
  assign pop = core_cfg_i.enable && rx_avail_i && (!res_valid_r || res_take_i);

  always_ff @(posedge noc_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      res_valid_r <= 1'b0;
    end
    else if (pop)
    begin
      res_valid_r <= 1'b1;
    end
    else if (res_take_i)
    begin
      res_valid_r <= 1'b0;
    end
  end

  // op and id ride along unchanged
  always_ff @(posedge noc_clk_i)
  begin
    if (pop)
    begin
      res_r.op   <= rx_flit_i.op;
      res_r.id   <= rx_flit_i.id;
      res_r.data <= xf_data;
    end
  end

  assign rx_pop_o    = pop;
  assign res_flit_o  = res_r;
  assign res_valid_o = res_valid_r;

endmodule

// ==== verilog/chip_link_pkg.sv ====
`include "chip_block_params.svh"

package chip_link_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // flit opcodes

  // what the core does to the payload
  typedef enum logic [1:0]
  {
    // payload unchanged
    OP_PASS = 2'b00,
    // payload plus key, wraps
    OP_ADD  = 2'b01,
    // payload xor key
    OP_XOR  = 2'b10,
    // rotate left by key low bits
    OP_ROTL = 2'b11
  } flit_op_e;

  ////////////////////////////////////////////////////////////////////////////
  // flit layout

  // sequence tag, carried through untouched
  localparam int flit_id_width_gp = 4;

  // one link beat, op in the top bits
  typedef struct packed
  {
    flit_op_e                      op;
    logic [flit_id_width_gp-1:0]   id;
    logic [`CHIP_FLIT_DATA_W-1:0]  data;
  } flit_s;

endpackage

// ==== verilog/chip_link_rx.sv ====
`timescale 1ns/1ps

`include "chip_block_params.svh"

module chip_link_rx
  (input  logic                  noc_clk_i
  ,input  logic                  rst_n_i

  // off chip side
  ,input  logic                  link_v_i
  ,input  chip_link_pkg::flit_s  link_data_i
  ,output logic                  link_token_o

  // core side
  ,output chip_link_pkg::flit_s  rx_flit_o
  ,output logic                  rx_avail_o
  ,input  logic                  rx_pop_i
  );

  localparam int depth_lp = `CHIP_LINK_CREDITS;
  localparam int ptr_w_lp = (depth_lp > 1) ? $clog2(depth_lp) : 1;
  localparam int cnt_w_lp = $clog2(depth_lp + 1);

  chip_link_pkg::flit_s  mem_r [depth_lp];
  logic [ptr_w_lp-1:0]   wr_ptr_r;
  logic [ptr_w_lp-1:0]   rd_ptr_r;
  logic [cnt_w_lp-1:0]   count_r;
  logic                  token_r;
  logic                  full;

  ////////////////////////////////////////////////////////////////////////////
  // FIFO storage

  // sender credits keep this from overflowing
  always_ff @(posedge noc_clk_i)
  begin
    if (link_v_i)
    begin
      mem_r[wr_ptr_r] <= link_data_i;
    end
  end

  // pointers wrap at depth, count tracks occupancy
  always_ff @(posedge noc_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end
    else
    begin
      if (link_v_i)
      begin
        wr_ptr_r <= (wr_ptr_r == ptr_w_lp'(depth_lp - 1)) ? '0 : wr_ptr_r + 1'b1;
      end
      if (rx_pop_i)
      begin
        rd_ptr_r <= (rd_ptr_r == ptr_w_lp'(depth_lp - 1)) ? '0 : rd_ptr_r + 1'b1;
      end
      case ({link_v_i, rx_pop_i})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

  assign full       = (count_r == cnt_w_lp'(depth_lp));
  assign rx_avail_o = (count_r != '0);
  // head of queue
  assign rx_flit_o  = mem_r[rd_ptr_r];

  ////////////////////////////////////////////////////////////////////////////
  // token return

  // one token per drained slot, a cycle after the pop
  always_ff @(posedge noc_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      token_r <= 1'b0;
    end
    else
    begin
      token_r <= rx_pop_i;
    end
  end

  assign link_token_o = token_r;

  // sender overran its credits
  no_write_full: assert property (@(posedge noc_clk_i) disable iff (!rst_n_i)
    link_v_i |-> !full);

  // core popped with nothing queued
  no_pop_empty: assert property (@(posedge noc_clk_i) disable iff (!rst_n_i)
    rx_pop_i |-> rx_avail_o);

endmodule

// ==== verilog/chip_link_tx.sv ====
`timescale 1ns/1ps

`include "chip_block_params.svh"

module chip_link_tx
  (input  logic                  noc_clk_i
  ,input  logic                  rst_n_i

  // core side
  ,input  chip_link_pkg::flit_s  res_flit_i
  ,input  logic                  res_valid_i
  ,output logic                  res_take_o

  // off chip side
  ,output logic                  link_v_o
  ,output chip_link_pkg::flit_s  link_data_o
  ,input  logic                  link_token_i
  );

  localparam int credits_lp = `CHIP_LINK_CREDITS;
  localparam int cnt_w_lp   = $clog2(credits_lp + 1);

  logic [cnt_w_lp-1:0]   credit_r;
  logic                  take;
  logic                  link_v_r;
  chip_link_pkg::flit_s  link_data_r;

  ////////////////////////////////////////////////////////////////////////////
  // credit counter

  // send only with a credit in hand
  assign take = res_valid_i && (credit_r != '0);

  // send and token in the same cycle cancel out
  always_ff @(posedge noc_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      credit_r <= cnt_w_lp'(credits_lp);
    end
    else
    begin
      case ({take, link_token_i})
        2'b10:   credit_r <= credit_r - 1'b1;
        2'b01:   credit_r <= credit_r + 1'b1;
        default: credit_r <= credit_r;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // output register

  always_ff @(posedge noc_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      link_v_r <= 1'b0;
    end
    else
    begin
      link_v_r <= take;
    end
  end

  // data only meaningful with link_v_o
  always_ff @(posedge noc_clk_i)
  begin
    if (take)
    begin
      link_data_r <= res_flit_i;
    end
  end

  assign res_take_o  = take;
  assign link_v_o    = link_v_r;
  assign link_data_o = link_data_r;

  // receiver returned more tokens than flits sent
  credit_bound: assert property (@(posedge noc_clk_i) disable iff (!rst_n_i)
    credit_r <= cnt_w_lp'(credits_lp));

endmodule

// ==== verilog/chip_tag_client.sv ====
`timescale 1ns/1ps

`include "chip_block_params.svh"

module chip_tag_client
  #(parameter logic [`CHIP_NODE_ID_W-1:0] node_id_p = '0)
  (input  logic                     noc_clk_i
  ,input  logic                     rst_n_i

  ,input  logic                     tag_en_i
  ,input  logic                     tag_data_i

  ,output chip_cfg_pkg::core_cfg_s  core_cfg_o
  );

  localparam int frame_len_lp = `CHIP_TAG_FRAME_LEN;
  localparam int id_w_lp      = `CHIP_NODE_ID_W;
  localparam int data_w_lp    = `CHIP_FLIT_DATA_W;
  localparam int cnt_w_lp     = $clog2(frame_len_lp + 1);

  chip_cfg_pkg::tag_state_e  state_r;
  logic [frame_len_lp-1:0]   shift_r;
  logic [cnt_w_lp-1:0]       bit_cnt_r;
  logic                      over_r;
  logic                      frame_end;
  logic                      frame_ok;
  chip_cfg_pkg::core_cfg_s   cfg_r;

  ////////////////////////////////////////////////////////////////////////////
  // deserializer

  // msb first, so the node id ends up on top
  always_ff @(posedge noc_clk_i)
  begin
    if (tag_en_i)
    begin
      shift_r <= {shift_r[frame_len_lp-2:0], tag_data_i};
    end
  end

  // bit counter saturates at the frame length
  // extra bits only set the overrun flag
  always_ff @(posedge noc_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state_r   <= chip_cfg_pkg::TAG_IDLE;
      bit_cnt_r <= '0;
      over_r    <= 1'b0;
    end
    else
    begin
      case (state_r)
        chip_cfg_pkg::TAG_IDLE:
        begin
          if (tag_en_i)
          begin
            // first bit lands on this edge
            state_r   <= chip_cfg_pkg::TAG_SHIFT;
            bit_cnt_r <= cnt_w_lp'(1);
            over_r    <= 1'b0;
          end
        end
        chip_cfg_pkg::TAG_SHIFT:
        begin
          if (!tag_en_i)
          begin
            state_r   <= chip_cfg_pkg::TAG_IDLE;
            bit_cnt_r <= '0;
          end
          else if (bit_cnt_r == cnt_w_lp'(frame_len_lp))
          begin
            over_r <= 1'b1;
          end
          else
          begin
            bit_cnt_r <= bit_cnt_r + 1'b1;
          end
        end
        default:
        begin
          state_r <= chip_cfg_pkg::TAG_IDLE;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // frame check and commit

  // falling edge of the frame strobe
  assign frame_end = (state_r == chip_cfg_pkg::TAG_SHIFT) && !tag_en_i;

  // exact length and our id, anything else is dropped
  assign frame_ok = (bit_cnt_r == cnt_w_lp'(frame_len_lp)) && !over_r
                 && (shift_r[frame_len_lp-1 -: id_w_lp] == node_id_p);

  always_ff @(posedge noc_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      cfg_r <= '0;
    end
    else if (frame_end && frame_ok)
    begin
      cfg_r.enable <= shift_r[data_w_lp];
      cfg_r.key    <= shift_r[data_w_lp-1:0];
    end
  end

  assign core_cfg_o = cfg_r;

  // counter stays within one frame
  cnt_in_range: assert property (@(posedge noc_clk_i) disable iff (!rst_n_i)
    bit_cnt_r <= cnt_w_lp'(frame_len_lp));

endmodule
